/* flist.f */
+incdir+include
src/icache_pkg.sv
src/icache_if_pkg.sv
src/icache_way_array.sv
src/icache_memory.sv
src/icache_replace_unit.sv
src/icache_checker.sv
src/icache_ctrl.sv
src/top_icache.sv
sim/icache_asserts.sv
sim/tb_top_icache.sv

/* include/icache_macros.svh */
// Geometry of the two-way instruction cache
// Pages are 256 bytes, so the set number lies in the untranslated page index
// One fill beat must carry a whole line; the set count must be 2**SET_BITS
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// -------------------------------------------------------------------------
// Organization
`define ICACHE_N_WAY        2
`define ICACHE_N_SET        16
`define ICACHE_LINE_BITS    128     // Single-beat line
`define ICACHE_OFFSET_BITS  4       // Byte offset within a line

// -------------------------------------------------------------------------
// Address widths
`define ICACHE_IDX_BITS     8       // Page index, never translated
`define ICACHE_VPN_BITS     24
`define ICACHE_PPN_BITS     24

// Derived widths
`define ICACHE_SET_BITS     (`ICACHE_IDX_BITS - `ICACHE_OFFSET_BITS)
`define ICACHE_VADDR_BITS   (`ICACHE_VPN_BITS + `ICACHE_IDX_BITS)
`define ICACHE_PADDR_BITS   (`ICACHE_PPN_BITS + `ICACHE_SET_BITS)

`endif

/* run.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_top_icache -f flist.f

out=$(./obj_dir/Vtb_top_icache 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

/* sim/icache_asserts.sv */
// Protocol checks bound into the cache top level
// Sampled on the rising clock, disabled while reset is held

`timescale 1ns/1ps

module icache_asserts import icache_pkg::*, icache_if_pkg::*; (
    input logic        clk_i,
    input logic        rst_n_i,
    input iresp_t      iresp_i,
    input treq_t       treq_i,
    input ifill_req_t  ifill_req_i,
    input ifill_resp_t ifill_resp_i
);

    // No new request while a lookup or refill is pending
    busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (treq_i.valid || ifill_req_i.valid) |-> !iresp_i.ready)
        else $error("iresp.ready high while a lookup or refill is pending");

    fill_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ifill_req_i.valid && !ifill_resp_i.valid) |=> ifill_req_i.valid)
        else $error("ifill_req.valid dropped before the fill response");

    resp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        iresp_i.valid |=> !iresp_i.valid)   // Strobe only
        else $error("iresp.valid high for two cycles in a row");

endmodule

bind top_icache icache_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .iresp_i      (iresp_o),
    .treq_i       (treq_o),
    .ifill_req_i  (ifill_req_o),
    .ifill_resp_i (ifill_resp_i)
);

/* sim/tb_top_icache.sv */
// Testbench for the two-way instruction cache
// MMU and refill port are modeled here; the MMU delay comes from the stimulus table
// Refill delay is random with a fixed seed, 1 to 4 cycles after the request is seen
// One request at a time; a request ends when the cache is ready again

`timescale 1ns/1ps

`include "icache_macros.svh"

module tb_top_icache import icache_pkg::*, icache_if_pkg::*; ();

    typedef struct packed {
        icache_vpn_t vpn;
        icache_idx_t idx;
        int          kill_cyc;   // Cycle after acceptance or 0 for none
        logic        flush;      // Flush before the request
        logic        xcpt;
        int          mmu_dly;    // 1 to 3
        logic        exp_hit;
    } row_t;

    localparam int          N_ROWS         = 14;
    localparam int          TIMEOUT_CYCLES = N_ROWS * 20;
    localparam icache_tag_t PPN_MASK       = 24'h5a5a5a;

    logic        clk;
    logic        rst_n;
    logic        flush;
    ireq_t       ireq;
    iresp_t      iresp;
    treq_t       treq;
    tresp_t      tresp;
    ifill_req_t  fill_req;
    ifill_resp_t fill_resp;
    row_t        rows [N_ROWS];
    integer      seed;
    int          cycle_cnt;

    // Reference model of valid bits, tags and round-robin pointers
    logic [`ICACHE_N_WAY-1:0] ref_valid [`ICACHE_N_SET];
    icache_tag_t              ref_tag   [`ICACHE_N_SET][`ICACHE_N_WAY];
    icache_way_t              ref_rr    [`ICACHE_N_SET];

    top_icache u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .ireq_i       (ireq),
        .iresp_o      (iresp),
        .tresp_i      (tresp),
        .treq_o       (treq),
        .ifill_resp_i (fill_resp),
        .ifill_req_o  (fill_req)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            abort_run("Timeout: the cache stopped answering before the table was done");
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic expect_true(input logic ok, input string what);
        assert (ok) else abort_run($sformatf("[ERROR] %0t: %s", $time, what));
    endtask

    // Refill line of four words, each the line address plus its word index
    function automatic icache_line_t fill_line(input icache_paddr_t paddr);
        icache_line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = {4'h0, paddr} + 32'(w);
        end
        return line;
    endfunction

    function automatic icache_way_t ref_victim(input icache_set_t s);
        if (!ref_valid[s][0]) return 1'b0;   // Lowest invalid way first
        if (!ref_valid[s][1]) return 1'b1;
        return ref_rr[s];
    endfunction

    // ------------------------------------------------------------------------
    // One table row with optional flush, request, MMU and refill answers
    task automatic run_row(input row_t r);
        icache_set_t   s;
        icache_tag_t   ptag;
        icache_paddr_t paddr;
        icache_way_t   victim;
        logic          hit;
        logic          killed;
        logic          fill_seen;
        logic          fill_done;
        logic          done;
        int            cyc;
        int            fill_cnt;
        int            fill_dly;
        int            resp_cnt;

        s         = r.idx[7:4];
        ptag      = r.vpn ^ PPN_MASK;
        paddr     = {ptag, s};
        killed    = 1'b0;
        fill_seen = 1'b0;
        fill_done = 1'b0;
        done      = 1'b0;
        cyc       = 0;
        fill_cnt  = 0;
        fill_dly  = 0;
        resp_cnt  = 0;

        if (r.flush) begin
            @(posedge clk);
            #1;
            flush = 1'b1;
            for (int i = 0; i < `ICACHE_N_SET; i++) ref_valid[i] = '0;
        end

        // Prediction from the model state after any flush
        victim = ref_victim(s);
        hit    = 1'b0;
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            hit = hit | (ref_valid[s][w] && (ref_tag[s][w] == ptag));
        end
        assert (r.xcpt || (hit == r.exp_hit))
            else abort_run("Stimulus table and reference model disagree on hit or miss");

        @(posedge clk);
        #1;
        flush       = 1'b0;
        tresp.valid = 1'b0;
        ireq.kill   = 1'b0;
        ireq.valid  = 1'b1;
        ireq.vpn    = r.vpn;
        ireq.idx    = r.idx;
        @(negedge clk);
        expect_true(iresp.ready, "cache not ready for a new request");

        while (!done) begin
            @(posedge clk);
            #1;
            cyc++;
            ireq.valid      = 1'b0;
            ireq.kill       = (cyc == r.kill_cyc);
            killed          = killed | ireq.kill;
            tresp.valid     = (cyc == r.mmu_dly);
            tresp.ppn       = ptag;
            tresp.xcpt      = r.xcpt;
            fill_resp.valid = 1'b0;
            if (fill_seen && !fill_done) begin
                fill_cnt++;
                if (fill_cnt == fill_dly) begin
                    fill_resp.valid = 1'b1;
                    fill_resp.data  = fill_line(paddr);
                    fill_done       = 1'b1;
                end
            end
            @(negedge clk);
            // MMU request is held from acceptance up to its answer
            if (cyc <= r.mmu_dly) begin
                expect_true(treq.valid && (treq.vpn == r.vpn),
                            $sformatf("treq valid %0b vpn %h, expected vpn %h",
                                      treq.valid, treq.vpn, r.vpn));
            end else begin
                expect_true(!treq.valid, "treq.valid still high after the MMU answer");
            end
            if (iresp.valid) begin
                resp_cnt++;
                expect_true(!killed, "response given for a killed request");
                expect_true(iresp.xcpt == r.xcpt,
                            $sformatf("xcpt %0b, expected %0b", iresp.xcpt, r.xcpt));
                expect_true(iresp.vaddr == {r.vpn, r.idx},
                            $sformatf("vaddr %h, expected %h", iresp.vaddr, {r.vpn, r.idx}));
                if (!r.xcpt) begin
                    expect_true(iresp.data == fill_line(paddr),
                                $sformatf("data %h, expected %h", iresp.data, fill_line(paddr)));
                end
                if (r.xcpt || hit) begin
                    expect_true(cyc == r.mmu_dly, "response not in the MMU answer cycle");
                end else begin
                    expect_true(fill_done, "miss answered before the fill");
                end
            end
            if (fill_req.valid && !fill_seen) begin
                fill_seen = 1'b1;
                expect_true(!r.xcpt && !hit, "refill requested on a hit or an exception");
                expect_true(fill_req.paddr == paddr,
                            $sformatf("fill paddr %h, expected %h", fill_req.paddr, paddr));
                expect_true(fill_req.way == victim,
                            $sformatf("fill way %0d, expected %0d", fill_req.way, victim));
                fill_dly = 1 + int'($unsigned($random(seed)) % 4);
            end
            done = iresp.ready;
        end

        expect_true(resp_cnt == (killed ? 0 : 1), $sformatf("%0d responses seen", resp_cnt));
        expect_true(fill_seen == (!r.xcpt && !hit), "refill request missing on a miss");
        if (!r.xcpt && !hit) begin   // Fill completes even when killed
            if (&ref_valid[s]) ref_rr[s] = ~ref_rr[s];
            ref_valid[s][victim] = 1'b1;
            ref_tag[s][victim]   = ptag;
        end
    endtask

    initial begin
        seed      = 32'hbab8b547;
        cycle_cnt = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        ireq      = '0;
        tresp     = '0;
        fill_resp = '0;
        for (int i = 0; i < `ICACHE_N_SET; i++) begin
            ref_valid[i]  = '0;
            ref_rr[i]     = '0;
            ref_tag[i][0] = '0;
            ref_tag[i][1] = '0;
        end

        // vpn, idx, kill cycle, flush, xcpt, MMU delay, expected hit
        rows[0]  = '{24'h000100, 8'h30, 0, 1'b0, 1'b0, 1, 1'b0};
        rows[1]  = '{24'h000100, 8'h34, 0, 1'b0, 1'b0, 2, 1'b1};
        rows[2]  = '{24'h000200, 8'h38, 0, 1'b0, 1'b0, 3, 1'b0};
        rows[3]  = '{24'h000300, 8'h30, 0, 1'b0, 1'b0, 1, 1'b0};   // Evicts 100
        rows[4]  = '{24'h000100, 8'h30, 0, 1'b0, 1'b0, 2, 1'b0};   // Misses again
        rows[5]  = '{24'h000300, 8'h3c, 0, 1'b0, 1'b0, 1, 1'b1};
        rows[6]  = '{24'h000400, 8'h50, 0, 1'b0, 1'b1, 2, 1'b0};   // MMU exception
        rows[7]  = '{24'h000500, 8'h70, 2, 1'b0, 1'b0, 3, 1'b0};   // Killed in lookup
        rows[8]  = '{24'h000500, 8'h74, 0, 1'b0, 1'b0, 1, 1'b1};
        rows[9]  = '{24'h000600, 8'ha0, 3, 1'b0, 1'b0, 1, 1'b0};   // Killed in refill
        rows[10] = '{24'h000600, 8'ha4, 0, 1'b0, 1'b0, 2, 1'b1};
        rows[11] = '{24'h000300, 8'h30, 0, 1'b1, 1'b0, 1, 1'b0};   // After flush
        rows[12] = '{24'h000500, 8'h70, 0, 1'b0, 1'b0, 3, 1'b0};
        rows[13] = '{24'h000100, 8'h30, 0, 1'b0, 1'b0, 2, 1'b0};

        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(rows[i]);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* src/icache_checker.sv */
// Tag compare across all ways of the addressed set
// Purely combinational; at most one way is expected to hit
// line_o is zero when nothing hits

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_checker import icache_pkg::*; (
    input  icache_way_tags_t  tags_i,
    input  icache_way_lines_t lines_i,
    input  icache_way_vec_t   valid_i,
    input  icache_tag_t       ptag_i,
    output logic              hit_o,
    output icache_way_vec_t   hit_way_o,
    output icache_line_t      line_o
);

    always_comb begin
        hit_way_o = '0;
        line_o    = '0;
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            // Only valid entries may match
            if (valid_i[w] && (tags_i[w] == ptag_i)) begin
                hit_way_o[w] = 1'b1;
                line_o       = lines_i[w];
            end
        end
    end

    assign hit_o = |hit_way_o;

endmodule

/* src/icache_ctrl.sv */
// Request FSM of the instruction cache
// One request at a time; flush is only taken in IDLE
// A kill hides the response but lets an ongoing refill finish

`timescale 1ns/1ps

module icache_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic accept_i,        // Request taken this cycle
    input  logic kill_i,
    input  logic flush_i,
    input  logic tresp_valid_i,   // MMU answer for the pending lookup
    input  logic xcpt_i,
    input  logic hit_i,
    input  logic fill_valid_i,
    output logic ready_o,
    output logic treq_valid_o,
    output logic resp_valid_o,
    output logic fill_req_o,
    output logic fill_we_o,
    output logic flush_en_o
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        REPLAY
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   kill_q;
    logic   killed;
    logic   resp_due;

    // -------------------------------------------------------------------------
    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (tresp_valid_i) begin
                    state_d = (xcpt_i || hit_i) ? IDLE : FILL;
                end
            end
            FILL: begin
                if (fill_valid_i) begin
                    state_d = REPLAY;
                end
            end
            default: state_d = IDLE;   // REPLAY lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            kill_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept_i) begin
                kill_q <= 1'b0;                    // Fresh request
            end else if (kill_i && (state_q != IDLE)) begin
                kill_q <= 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Outputs
    assign killed   = kill_q | kill_i;
    assign resp_due = ((state_q == LOOKUP) && tresp_valid_i && (xcpt_i || hit_i))
                      || (state_q == REPLAY);

    assign ready_o      = (state_q == IDLE) && !flush_i;
    assign flush_en_o   = (state_q == IDLE) && flush_i;
    assign treq_valid_o = (state_q == LOOKUP);
    assign fill_req_o   = (state_q == FILL);
    assign fill_we_o    = (state_q == FILL) && fill_valid_i;
    assign resp_valid_o = resp_due && !killed;

endmodule

/* src/icache_if_pkg.sv */
// Port bundles of the instruction cache towards fetch, MMU and refill
// The MMU always answers; there is no retry or miss indication
// A refill response carries the whole line in a single beat

`include "icache_macros.svh"

package icache_if_pkg;

    import icache_pkg::*;

    typedef logic [`ICACHE_VADDR_BITS-1:0] icache_vaddr_t;
    typedef logic [`ICACHE_PADDR_BITS-1:0] icache_paddr_t;   // Line address

    // -------------------------------------------------------------------------
    // Fetch unit
    typedef struct packed {
        logic          valid;
        logic          kill;     // Cancels the outstanding response
        icache_vpn_t   vpn;
        icache_idx_t   idx;
    } ireq_t;

    typedef struct packed {
        logic          ready;
        logic          valid;    // One-cycle strobe
        logic          xcpt;
        icache_vaddr_t vaddr;
        icache_line_t  data;
    } iresp_t;

    // -------------------------------------------------------------------------
    // MMU
    typedef struct packed {
        logic          valid;
        icache_vpn_t   vpn;
    } treq_t;

    typedef struct packed {
        logic          valid;
        icache_tag_t   ppn;
        logic          xcpt;
    } tresp_t;

    // -------------------------------------------------------------------------
    // Line refill
    typedef struct packed {
        logic          valid;    // Level, held until the fill beat
        icache_paddr_t paddr;
        icache_way_t   way;
    } ifill_req_t;

    typedef struct packed {
        logic          valid;
        icache_line_t  data;
    } ifill_resp_t;

endpackage

/* src/icache_memory.sv */
// Tag and data arrays for all ways plus the valid-bit matrix
// A flush clears every valid bit in one cycle and wins over a write
// A write always sets the valid bit of the written way

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_memory import icache_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  icache_set_t       set_i,
    input  icache_way_vec_t   we_way_i,
    input  logic              flush_i,
    input  icache_tag_t       tag_i,
    input  icache_line_t      line_i,
    output icache_way_tags_t  tags_o,
    output icache_way_lines_t lines_o,
    output icache_way_vec_t   valid_o
);

    logic [`ICACHE_N_SET-1:0][`ICACHE_N_WAY-1:0] valid_q;

    // -------------------------------------------------------------------------
    // Arrays, one tag and one line store per way
    for (genvar w = 0; w < `ICACHE_N_WAY; w++) begin : g_way
        icache_way_array #(
            .entry_t (icache_tag_t)
        ) u_tag_array (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .we_i    (we_way_i[w]),
            .set_i   (set_i),
            .wdata_i (tag_i),
            .rdata_o (tags_o[w])
        );

        icache_way_array #(
            .entry_t (icache_line_t)
        ) u_line_array (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .we_i    (we_way_i[w]),
            .set_i   (set_i),
            .wdata_i (line_i),
            .rdata_o (lines_o[w])
        );
    end

    // -------------------------------------------------------------------------
    // Valid bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;                               // Whole cache at once
        end else begin
            valid_q[set_i] <= valid_q[set_i] | we_way_i;
        end
    end

    assign valid_o = valid_q[set_i];

endmodule

/* src/icache_pkg.sv */
// Internal types of the instruction cache
// The tag is the full physical page number, so no index bits are stored
// Way arrays are packed with one entry per way, way 0 in the low bits

`include "icache_macros.svh"

package icache_pkg;

    // Address fields
    typedef logic [`ICACHE_IDX_BITS-1:0]  icache_idx_t;
    typedef logic [`ICACHE_SET_BITS-1:0]  icache_set_t;   // Index bits 7..4
    typedef logic [`ICACHE_VPN_BITS-1:0]  icache_vpn_t;
    typedef logic [`ICACHE_PPN_BITS-1:0]  icache_tag_t;   // Equal to the PPN

    // Payload
    typedef logic [`ICACHE_LINE_BITS-1:0] icache_line_t;

    // Way selection
    typedef logic [$clog2(`ICACHE_N_WAY)-1:0] icache_way_t;
    typedef logic [`ICACHE_N_WAY-1:0]         icache_way_vec_t;   // One bit per way

    // Read ports of all ways side by side
    typedef icache_tag_t  [`ICACHE_N_WAY-1:0] icache_way_tags_t;
    typedef icache_line_t [`ICACHE_N_WAY-1:0] icache_way_lines_t;

endpackage

/* src/icache_replace_unit.sv */
// Victim choice per set: lowest invalid way first, else round robin
// The pointer of a set advances only on a fill into a full set
// valid_i must show the bits as they were before the fill is written

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_replace_unit import icache_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  icache_set_t     set_i,
    input  icache_way_vec_t valid_i,
    input  logic            fill_i,
    output icache_way_t     victim_o
);

    icache_way_t [`ICACHE_N_SET-1:0] rr_q;   // Round-robin pointer per set
    logic                            set_full;

    assign set_full = &valid_i;

    // Downward scan so the lowest invalid way is the last one assigned
    always_comb begin
        victim_o = rr_q[set_i];
        for (int w = `ICACHE_N_WAY - 1; w >= 0; w--) begin
            if (!valid_i[w]) begin
                victim_o = icache_way_t'(w);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_q <= '0;
        end else if (fill_i && set_full) begin
            rr_q[set_i] <= rr_q[set_i] + 1'b1;     // Wraps with two ways
        end
    end

endmodule

/* src/icache_way_array.sv */
// Storage of one way for a single payload type, one entry per set
// Read is asynchronous, write takes effect at the next clock edge
// Contents are not cleared by reset; the valid bits live elsewhere

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_way_array import icache_pkg::*; #(
    parameter type entry_t = icache_tag_t
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        we_i,
    input  icache_set_t set_i,
    input  entry_t      wdata_i,
    output entry_t      rdata_o
);

    entry_t mem_q [`ICACHE_N_SET];

    // No writes while reset is held
    always_ff @(posedge clk_i) begin
        if (rst_n_i && we_i) begin
            mem_q[set_i] <= wdata_i;
        end
    end

    assign rdata_o = mem_q[set_i];   // Addressed entry, no read latency

endmodule

/* src/top_icache.sv */
// Two-way instruction cache between fetch unit, MMU and line refill
// The MMU must answer every request; there is no retry path
// One fill beat delivers the whole line, and all regions are cacheable
// A response is a single-cycle strobe and cannot be stalled

`timescale 1ns/1ps

`include "icache_macros.svh"

module top_icache import icache_pkg::*, icache_if_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  ireq_t       ireq_i,        // From fetch
    output iresp_t      iresp_o,       // To fetch
    input  tresp_t      tresp_i,       // From MMU
    output treq_t       treq_o,        // To MMU
    input  ifill_resp_t ifill_resp_i,  // From next level
    output ifill_req_t  ifill_req_o    // To next level
);

    icache_vpn_t       vpn_q;
    icache_idx_t       idx_q;
    icache_tag_t       ppn_q;
    icache_way_t       victim_q;
    icache_way_t       victim;
    icache_set_t       set;
    icache_tag_t       ptag;
    icache_way_vec_t   we_way;
    icache_way_vec_t   valid;
    icache_way_tags_t  tags;
    icache_way_lines_t lines;
    icache_line_t      hit_line;
    logic accept, tresp_take, hit;
    logic ready, treq_valid, resp_valid, fill_req, fill_we, flush_en;

    assign accept     = ireq_i.valid & ready;
    assign tresp_take = treq_valid & tresp_i.valid;   // MMU fields valid only here

    // -------------------------------------------------------------------------
    // Request and translation registers
    always_ff @(posedge clk_i) begin
        if (accept) begin
            vpn_q <= ireq_i.vpn;
            idx_q <= ireq_i.idx;
        end
        if (tresp_take) begin
            ppn_q    <= tresp_i.ppn;
            victim_q <= victim;       // Stable way for FILL and REPLAY
        end
    end

    assign set    = idx_q[`ICACHE_IDX_BITS-1:`ICACHE_OFFSET_BITS];
    assign ptag   = tresp_take ? tresp_i.ppn : ppn_q;   // Replay compares the stored PPN
    assign we_way = fill_we ? (icache_way_vec_t'(1) << victim_q) : '0;

    icache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .accept_i      (accept),
        .kill_i        (ireq_i.kill),
        .flush_i       (flush_i),
        .tresp_valid_i (tresp_take),
        .xcpt_i        (tresp_i.xcpt),
        .hit_i         (hit),
        .fill_valid_i  (ifill_resp_i.valid),
        .ready_o       (ready),
        .treq_valid_o  (treq_valid),
        .resp_valid_o  (resp_valid),
        .fill_req_o    (fill_req),
        .fill_we_o     (fill_we),
        .flush_en_o    (flush_en)
    );

    icache_memory u_memory (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .set_i    (set),
        .we_way_i (we_way),
        .flush_i  (flush_en),
        .tag_i    (ppn_q),
        .line_i   (ifill_resp_i.data),
        .tags_o   (tags),
        .lines_o  (lines),
        .valid_o  (valid)
    );

    icache_replace_unit u_replace (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .set_i    (set),
        .valid_i  (valid),
        .fill_i   (fill_we),
        .victim_o (victim)
    );

    icache_checker u_checker (
        .tags_i    (tags),
        .lines_i   (lines),
        .valid_i   (valid),
        .ptag_i    (ptag),
        .hit_o     (hit),
        .hit_way_o (),
        .line_o    (hit_line)
    );

    // -------------------------------------------------------------------------
    // Port bundles
    always_comb begin
        treq_o.valid      = treq_valid;
        treq_o.vpn        = vpn_q;
        ifill_req_o.valid = fill_req;
        ifill_req_o.paddr = {ppn_q, set};   // Line address
        ifill_req_o.way   = victim_q;
        iresp_o.ready     = ready;
        iresp_o.valid     = resp_valid;
        iresp_o.xcpt      = tresp_take & tresp_i.xcpt;
        iresp_o.vaddr     = {vpn_q, idx_q};
        iresp_o.data      = hit_line;
    end

endmodule
